// ==== vlog.f ====
+incdir+.
mat_pkg.sv
fmt_pkg.sv
title_rom.sv
elem_to_ascii.sv
print_sequencer.sv
display_formatter.sv
display_formatter_assertions.sv
tb_display_formatter.sv

// ==== Makefile ====
# Verilator build and run of the display formatter testbench

TOP = tb_display_formatter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f vlog.f

# pass only when the run prints the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== tb_display_formatter.sv ====
`timescale 1ns/1ps
`include "mfmt_consts.svh"

module tb_display_formatter;
    import mat_pkg::*;
    import fmt_pkg::*;

    // worst case over all tests, 5 chars per element and 17 per title
    localparam int N_ELEMS     = 6 + 6 + 6 + `MFMT_DIM_MAX * `MFMT_DIM_MAX + 9 + 4;
    localparam int MAX_CHARS   = N_ELEMS * 5 + 6 * 17;
    localparam int WATCHDOG_NS = (MAX_CHARS + 8 * N_ELEMS) * 4 * 100 + 10_000 + 200 * 100;

    logic        clk;
    logic        rst_n;
    logic        start;
    disp_mode_e  mode;
    mat_desc_t   desc;
    elem_t       matrix_data       = '0;
    logic        matrix_data_valid = 1'b0;
    logic        tx_busy           = 1'b0;
    logic        data_req;
    tx_beat_t    tx;
    logic        format_done;

    elem_t       elem_list[$];   // elements of the running job
    char_t       exp_q[$];       // characters still expected
    char_t       exp_ch;
    int          elem_idx     = 0;
    int          delay_left   = 0;
    logic        busy_rand    = 1'b0;
    logic        valid_delay  = 1'b0;
    logic [31:0] rand_state   = 32'hac6c7bf9;
    logic [31:0] drv_state    = 32'hac6c7bf9;
    int          err_cnt      = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    display_formatter dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_errors();
        return err_cnt + dut_i.u_checks.err_cnt;   // bound checker counts too
    endfunction

    task automatic fill_random(input int count);
        elem_list.delete();
        repeat (count) begin
            rand_state = lcg_next(rand_state);
            elem_list.push_back(elem_t'(rand_state[31:24]));
        end
    endtask

    task automatic push_text(input string s);
        for (int i = 0; i < s.len(); i++) exp_q.push_back(char_t'(s[i]));
    endtask

    // expected stream: title, elements with separators, final newline
    task automatic build_expected(input disp_mode_e md, input mat_desc_t d);
        int cols;
        int k;
        cols = int'(d.n);
        exp_q.delete();
        if (md == MODE_MATRIX) begin
            push_text($sformatf("Matrix %0d (%0dx%0d):", d.id, d.m, d.n));
        end else begin
            push_text($sformatf("Result (%0dx%0d):", d.m, d.n));
        end
        exp_q.push_back(`MFMT_CH_NL);
        for (k = 0; k < int'(d.m) * cols; k++) begin
            push_text($sformatf("%0d", int'(elem_list[k])));
            exp_q.push_back((k % cols == cols - 1) ? `MFMT_CH_NL : `MFMT_CH_SP);
        end
        exp_q.push_back(`MFMT_CH_NL);
    endtask

    task automatic format_job(input string name, input disp_mode_e md, input mat_desc_t d);
        int limit;
        int cycles;
        limit  = 40 * elem_list.size() + 100;
        cycles = 0;
        build_expected(md, d);
        @(negedge clk);
        mode  = md;
        desc  = d;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!format_done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!format_done) begin
            $display("%s: format_done did not arrive within %0d cycles", name, limit);
            err_cnt++;
        end
        @(negedge clk);   // monitor sees the done cycle first
    endtask

    task automatic report(input string name, input int errs_before);
        tests_run++;
        if (total_errors() == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name,
                     total_errors() - errs_before);
        end
    endtask

    task automatic run_test(input string name, input disp_mode_e md, input mat_desc_t d);
        int errs_before;
        errs_before = total_errors();
        format_job(name, md, d);
        report(name, errs_before);
    endtask

    task automatic check_ignored_start();
        int errs_before;
        errs_before = total_errors();
        @(negedge clk);
        mode  = disp_mode_e'(2'd1);   // unsupported mode code
        desc  = '{id: 4'd2, m: 3'd2, n: 3'd2};
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (200) begin
            @(negedge clk);
            checks++;
            assert (!tx.valid && !format_done && !data_req)
                else begin
                    $display("** Error @%0t: output activity after a start with mode 1", $time);
                    err_cnt++;
                end
        end
        fill_random(4);
        format_job("ignored mode then matrix 2x2", MODE_MATRIX, '{id: 4'd0, m: 3'd2, n: 3'd2});
        report("ignored mode then matrix 2x2", errs_before);
    endtask

    // uart busy model and element source
    always @(negedge clk) begin
        if (rst_n) begin
            drv_state = lcg_next(drv_state);
            tx_busy   = busy_rand && drv_state[30];   // about half the cycles
            if (matrix_data_valid && !data_req) begin  // taken on the last edge
                matrix_data_valid = 1'b0;
                elem_idx++;
                delay_left = valid_delay ? int'(drv_state[27:25]) : 0;
            end
            if (data_req && !matrix_data_valid) begin
                if (elem_idx >= elem_list.size()) begin
                    $display("element %0d requested beyond the end of the matrix", elem_idx);
                    err_cnt++;
                end else if (delay_left == 0) begin
                    matrix_data       = elem_list[elem_idx];
                    matrix_data_valid = 1'b1;
                end else begin
                    delay_left--;
                end
            end
            if (format_done) elem_idx = 0;   // next job starts from the top
        end
    end

    // compares every beat against the expected queue
    always @(negedge clk) begin
        if (rst_n && tx.valid) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("** Error @%0t: unexpected character 0x%02h", $time, tx.data);
                err_cnt++;
            end else begin
                exp_ch = exp_q.pop_front();
                assert (tx.data == exp_ch)
                    else begin
                        $display("** Error @%0t: expected 0x%02h, got 0x%02h",
                                 $time, exp_ch, tx.data);
                        err_cnt++;
                    end
            end
        end
        if (rst_n && format_done) begin
            checks++;
            assert (exp_q.size() == 0)
                else begin
                    $display("** Error @%0t: format_done with %0d characters missing",
                             $time, exp_q.size());
                    err_cnt++;
                end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT did not finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        mode  = MODE_MATRIX;
        desc  = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        fill_random(6);
        run_test("matrix 2x3", MODE_MATRIX, '{id: 4'd1, m: 3'd2, n: 3'd3});
        fill_random(6);
        run_test("result 3x2", MODE_RESULT, '{id: 4'd0, m: 3'd3, n: 3'd2});
        // -128 -100 -5 0 9 127
        elem_list = '{8'h80, 8'h9c, 8'hfb, 8'h00, 8'h09, 8'h7f};
        run_test("edge values 1x6", MODE_MATRIX, '{id: 4'd3, m: 3'd1, n: 3'd6});
        fill_random(`MFMT_DIM_MAX * `MFMT_DIM_MAX);
        busy_rand = 1'b1;
        run_test("matrix 7x7 random busy", MODE_MATRIX,
                 '{id: 4'(`MFMT_ID_MAX), m: 3'(`MFMT_DIM_MAX), n: 3'(`MFMT_DIM_MAX)});
        busy_rand = 1'b0;
        fill_random(9);
        valid_delay = 1'b1;
        run_test("result 3x3 delayed valid", MODE_RESULT, '{id: 4'd5, m: 3'd3, n: 3'd3});
        valid_delay = 1'b0;
        check_ignored_start();

        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, checks, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== display_formatter_assertions.sv ====
`timescale 1ns/1ps
`include "mfmt_consts.svh"

module display_formatter_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               data_req,
    input logic               matrix_data_valid,
    input fmt_pkg::tx_beat_t  tx,
    input logic               tx_busy,
    input logic               format_done
);
    int err_cnt = 0;   // failures seen so far

    // no beat in the cycle after busy
    busy_blocks_tx: assert property (@(posedge clk) disable iff (!rst_n)
        tx_busy |=> !tx.valid)
        else begin
            $error("tx.valid high in the cycle after tx_busy");
            err_cnt++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        format_done |=> !format_done)
        else begin
            $error("format_done longer than one cycle");
            err_cnt++;
        end

    // element handshake
    req_drops_after_take: assert property (@(posedge clk) disable iff (!rst_n)
        data_req && matrix_data_valid |=> !data_req)
        else begin
            $error("data_req still high after the element was taken");
            err_cnt++;
        end

    req_holds_until_valid: assert property (@(posedge clk) disable iff (!rst_n)
        data_req && !matrix_data_valid |=> data_req)
        else begin
            $error("data_req dropped before an element was taken");
            err_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !tx.valid && !data_req && !format_done)
        else begin
            $error("outputs active during reset");
            err_cnt++;
        end

    printable_data: assert property (@(posedge clk) disable iff (!rst_n)
        tx.valid |-> tx.data == `MFMT_CH_NL || (tx.data >= `MFMT_CH_SP && tx.data <= 8'h7e))
        else begin
            $error("tx data is neither printable nor a newline");
            err_cnt++;
        end

endmodule

bind display_formatter display_formatter_assertions u_checks (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_req          (data_req),
    .matrix_data_valid (matrix_data_valid),
    .tx                (tx),
    .tx_busy           (tx_busy),
    .format_done       (format_done)
);

// ==== display_formatter.sv ====
`timescale 1ns/1ps
`include "mfmt_consts.svh"

module display_formatter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  fmt_pkg::disp_mode_e  mode,
    input  mat_pkg::mat_desc_t   desc,
    input  mat_pkg::elem_t       matrix_data,
    input  logic                 matrix_data_valid,
    output logic                 data_req,
    output fmt_pkg::tx_beat_t    tx,
    input  logic                 tx_busy,
    output logic                 format_done
);
    import mat_pkg::*;
    import fmt_pkg::*;

    logic [`MFMT_TITLE_IDX_W-1:0] title_pos;
    disp_mode_e                   title_mode;
    mat_desc_t                    title_desc;
    char_t                        title_ch;
    logic                         title_last;

    logic                         elem_load;
    elem_t                        elem_in;
    logic                         elem_advance;
    char_t                        elem_ch;
    logic                         elem_last;

    print_sequencer u_seq (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .mode              (mode),
        .desc              (desc),
        .data_req          (data_req),
        .matrix_data       (matrix_data),
        .matrix_data_valid (matrix_data_valid),
        .tx                (tx),
        .tx_busy           (tx_busy),
        .format_done       (format_done),
        .title_pos         (title_pos),
        .title_mode        (title_mode),
        .title_desc        (title_desc),
        .title_ch          (title_ch),
        .title_last        (title_last),
        .elem_load         (elem_load),
        .elem_out          (elem_in),
        .elem_advance      (elem_advance),
        .elem_ch           (elem_ch),
        .elem_last         (elem_last)
    );

    title_rom u_title (
        .mode (title_mode),
        .desc (title_desc),
        .pos  (title_pos),
        .ch   (title_ch),
        .last (title_last)
    );

    elem_to_ascii u_elem (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (elem_load),
        .elem    (elem_in),
        .advance (elem_advance),
        .ch      (elem_ch),
        .last    (elem_last)
    );

endmodule

// ==== print_sequencer.sv ====
`timescale 1ns/1ps
`include "mfmt_consts.svh"

module print_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  fmt_pkg::disp_mode_e              mode,
    input  mat_pkg::mat_desc_t               desc,
    output logic                             data_req,
    input  mat_pkg::elem_t                   matrix_data,
    input  logic                             matrix_data_valid,
    output fmt_pkg::tx_beat_t                tx,
    input  logic                             tx_busy,
    output logic                             format_done,
    output logic [`MFMT_TITLE_IDX_W-1:0]     title_pos,
    output fmt_pkg::disp_mode_e              title_mode,
    output mat_pkg::mat_desc_t               title_desc,
    input  fmt_pkg::char_t                   title_ch,
    input  logic                             title_last,
    output logic                             elem_load,
    output mat_pkg::elem_t                   elem_out,
    output logic                             elem_advance,
    input  fmt_pkg::char_t                   elem_ch,
    input  logic                             elem_last
);
    import mat_pkg::*;
    import fmt_pkg::*;

    typedef logic [`MFMT_CNT_W-1:0] cnt_t;

    seq_phase_e phase;
    disp_mode_e mode_q;
    mat_desc_t  desc_q;
    dim_t       col_cnt;
    cnt_t       elem_cnt;
    cnt_t       elem_total;
    logic       mode_ok;
    logic       row_end;
    logic       all_sent;

    assign mode_ok    = (mode == MODE_MATRIX) || (mode == MODE_RESULT);
    assign elem_total = cnt_t'(desc_q.m) * cnt_t'(desc_q.n);
    assign row_end    = (col_cnt == desc_q.n - 1'b1);
    assign all_sent   = (elem_cnt == elem_total - 1'b1);

    // element handshake
    assign data_req     = (phase == PH_FETCH);
    assign elem_load    = data_req && matrix_data_valid;
    assign elem_out     = matrix_data;
    assign elem_advance = (phase == PH_DIGITS) && !tx_busy;

    assign title_mode = mode_q;
    assign title_desc = desc_q;

    // job parameters, taken with start
    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && start) begin
            mode_q <= mode;
            desc_q <= desc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= PH_IDLE;
            tx          <= '0;
            format_done <= 1'b0;
            title_pos   <= '0;
            col_cnt     <= '0;
            elem_cnt    <= '0;
        end else begin
            tx.valid    <= 1'b0;   // one cycle per character
            format_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start && mode_ok) begin   // other mode codes are ignored
                        phase     <= PH_TITLE;
                        title_pos <= '0;
                        col_cnt   <= '0;
                        elem_cnt  <= '0;
                    end
                end
                PH_TITLE: begin
                    if (!tx_busy) begin
                        tx        <= '{valid: 1'b1, data: title_ch};
                        title_pos <= title_pos + 1'b1;
                        if (title_last) phase <= PH_FETCH;
                    end
                end
                PH_FETCH: begin
                    if (matrix_data_valid) phase <= PH_DIGITS;
                end
                PH_DIGITS: begin
                    if (!tx_busy) begin
                        tx <= '{valid: 1'b1, data: elem_ch};
                        if (elem_last) phase <= PH_SEP;
                    end
                end
                PH_SEP: begin
                    if (!tx_busy) begin
                        tx.valid <= 1'b1;
                        tx.data  <= row_end ? `MFMT_CH_NL : `MFMT_CH_SP;
                        col_cnt  <= row_end ? '0 : col_cnt + 1'b1;
                        elem_cnt <= elem_cnt + 1'b1;
                        phase    <= all_sent ? PH_LAST_NL : PH_FETCH;
                    end
                end
                PH_LAST_NL: begin
                    if (!tx_busy) begin
                        tx    <= '{valid: 1'b1, data: `MFMT_CH_NL};
                        phase <= PH_DONE;
                    end
                end
                PH_DONE: begin
                    format_done <= 1'b1;   // lands after the final newline beat
                    phase       <= PH_IDLE;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

// ==== elem_to_ascii.sv ====
`timescale 1ns/1ps
`include "mfmt_consts.svh"

module elem_to_ascii (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  mat_pkg::elem_t  elem,
    input  logic            advance,
    output fmt_pkg::char_t  ch,
    output logic            last
);
    import fmt_pkg::*;

    logic       neg_q;
    logic [8:0] mag_q;    // one bit wider so -128 gives 128
    logic [1:0] ptr_q;    // at most 4 chars, "-128"

    logic       hund;
    logic [6:0] rem;
    logic [3:0] tens;
    logic [3:0] ones;

    char_t      seq [4];
    logic [1:0] last_idx;

    // sign and magnitude of the element
    always_ff @(posedge clk) begin
        if (load) begin
            neg_q <= elem[7];
            mag_q <= elem[7] ? 9'd0 - {elem[7], elem} : {1'b0, elem};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (load) begin
            ptr_q <= '0;
        end else if (advance) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    // decimal split by thresholds, magnitude never exceeds 128
    always_comb begin
        hund = (mag_q >= 9'd100);
        rem  = hund ? 7'(mag_q - 9'd100) : 7'(mag_q);
        tens = '0;
        for (int t = 1; t <= 9; t++) begin
            if (rem >= 7'(t * 10)) tens = 4'(t);   // highest match wins
        end
        ones = 4'(rem - 7'(tens * 10));
    end

    // pack the present characters to the front of the list
    always_comb begin
        logic [1:0] k;
        k   = '0;
        seq = '{default: `MFMT_CH_ZERO};
        if (neg_q) begin
            seq[k] = `MFMT_CH_MINUS;
            k      = k + 1'b1;
        end
        if (hund) begin
            seq[k] = `MFMT_CH_ZERO + 8'd1;
            k      = k + 1'b1;
        end
        if (hund || tens != 4'd0) begin   // inner zero stays, leading zero goes
            seq[k] = `MFMT_CH_ZERO + {4'b0, tens};
            k      = k + 1'b1;
        end
        seq[k]   = `MFMT_CH_ZERO + {4'b0, ones};
        last_idx = k;
    end

    assign ch   = seq[ptr_q];
    assign last = (ptr_q == last_idx);

endmodule

// ==== title_rom.sv ====
`timescale 1ns/1ps
`include "mfmt_consts.svh"

module title_rom (
    input  fmt_pkg::disp_mode_e              mode,
    input  mat_pkg::mat_desc_t               desc,
    input  logic [`MFMT_TITLE_IDX_W-1:0]     pos,
    output fmt_pkg::char_t                   ch,
    output logic                             last
);
    import fmt_pkg::*;

    char_t id_ch;
    char_t m_ch;
    char_t n_ch;

    assign id_ch = `MFMT_CH_ZERO + char_t'(desc.id);
    assign m_ch  = `MFMT_CH_ZERO + char_t'(desc.m);
    assign n_ch  = `MFMT_CH_ZERO + char_t'(desc.n);

    always_comb begin
        ch   = `MFMT_CH_SP;
        last = 1'b0;
        case (mode)
            MODE_MATRIX: begin   // "Matrix I (MxN):"
                case (pos)
                    5'd0:  ch = "M";
                    5'd1:  ch = "a";
                    5'd2:  ch = "t";
                    5'd3:  ch = "r";
                    5'd4:  ch = "i";
                    5'd5:  ch = "x";
                    5'd7:  ch = id_ch;
                    5'd9:  ch = `MFMT_CH_LPAR;
                    5'd10: ch = m_ch;
                    5'd11: ch = `MFMT_CH_X;
                    5'd12: ch = n_ch;
                    5'd13: ch = `MFMT_CH_RPAR;
                    5'd14: ch = `MFMT_CH_COLON;
                    5'd15: begin
                        ch   = `MFMT_CH_NL;
                        last = 1'b1;
                    end
                    default: ch = `MFMT_CH_SP;   // positions 6 and 8
                endcase
            end
            MODE_RESULT: begin   // "Result (MxN):"
                case (pos)
                    5'd0:  ch = "R";
                    5'd1:  ch = "e";
                    5'd2:  ch = "s";
                    5'd3:  ch = "u";
                    5'd4:  ch = "l";
                    5'd5:  ch = "t";
                    5'd7:  ch = `MFMT_CH_LPAR;
                    5'd8:  ch = m_ch;
                    5'd9:  ch = `MFMT_CH_X;
                    5'd10: ch = n_ch;
                    5'd11: ch = `MFMT_CH_RPAR;
                    5'd12: ch = `MFMT_CH_COLON;
                    5'd13: begin
                        ch   = `MFMT_CH_NL;
                        last = 1'b1;
                    end
                    default: ch = `MFMT_CH_SP;
                endcase
            end
            default: last = 1'b1;   // unknown mode ends the title at once
        endcase
    end

endmodule

// ==== fmt_pkg.sv ====
package fmt_pkg;

    // one ascii character
    typedef logic [7:0] char_t;

    // display mode, codes 1 and 3 are not supported
    typedef enum logic [1:0] {
        MODE_MATRIX = 2'd0,
        MODE_RESULT = 2'd2
    } disp_mode_e;

    // character offered to the uart
    typedef struct packed {
        logic  valid;
        char_t data;
    } tx_beat_t;

    // sequencer phases
    typedef enum logic [2:0] {
        PH_IDLE    = 3'd0,
        PH_TITLE   = 3'd1,
        PH_FETCH   = 3'd2,   // waiting on the element source
        PH_DIGITS  = 3'd3,
        PH_SEP     = 3'd4,   // space or newline after an element
        PH_LAST_NL = 3'd5,
        PH_DONE    = 3'd6
    } seq_phase_e;

endpackage

// ==== mat_pkg.sv ====
`include "mfmt_consts.svh"

package mat_pkg;

    // row or column count, 1..7
    typedef logic [`MFMT_DIM_W-1:0] dim_t;

    // one matrix element, two's complement
    typedef logic signed [7:0] elem_t;

    // what the caller hands over with start
    typedef struct packed {
        logic [`MFMT_ID_W-1:0] id;   // printed in the matrix title
        dim_t                  m;    // rows
        dim_t                  n;    // columns
    } mat_desc_t;

endpackage

// ==== mfmt_consts.svh ====
`ifndef MFMT_CONSTS_SVH
`define MFMT_CONSTS_SVH

// fixed ascii codes
`define MFMT_CH_NL      8'h0a   // line feed only, no carriage return
`define MFMT_CH_SP      8'h20
`define MFMT_CH_MINUS   8'h2d
`define MFMT_CH_ZERO    8'h30   // digits are offsets from here
`define MFMT_CH_X       8'h78   // lower case x between dims
`define MFMT_CH_LPAR    8'h28
`define MFMT_CH_RPAR    8'h29
`define MFMT_CH_COLON   8'h3a

// descriptor fields
`define MFMT_DIM_W      3
`define MFMT_ID_W       4

// largest values that still print as one digit
`define MFMT_DIM_MAX    7
`define MFMT_ID_MAX     9

// element counter, 7x7 = 49 needs 6 bits
`define MFMT_CNT_W      6

// title position, longest title is 16 chars
`define MFMT_TITLE_IDX_W 5

`endif
